// File: common/aib_link_pkg.sv
// ============================================================
// aib link package
// data path width, transmit loopback select and the link
// bring-up state encoding
// ============================================================

package aib_link_pkg;

  // default width of the adapter data path
  parameter int DATA_W = 40;

  // width of the bring-up state field
  parameter int LINK_STATE_W = 3;

  // transmit source select
  typedef enum logic
  {
    LPBK_OFF = 1'b0,   // mac data
    LPBK_RX  = 1'b1    // rx register data
  } lpbk_mode_e;

  // master-mode bring-up sequence
  typedef enum logic [LINK_STATE_W-1:0]
  {
    LINK_RESET   = 3'd0,
    LINK_OSC_EN  = 3'd1,
    LINK_TX_CAL  = 3'd2,
    LINK_RX_LOCK = 3'd3,
    LINK_ACTIVE  = 3'd4
  } link_state_e;

endpackage

// File: common/aib_cfg_pkg.sv
// ============================================================
// aib config package
// register map and field positions of the config block
// ============================================================

package aib_cfg_pkg;

  parameter int CFG_ADDR_W = 17;
  parameter int CFG_DATA_W = 32;

  // register addresses
  typedef enum logic [CFG_ADDR_W-1:0]
  {
    CFG_CHNL_CTRL   = 17'd0,
    CFG_USER_CTRL   = 17'd1,
    CFG_LINK_STATUS = 17'd2   // read only
  } cfg_addr_e;

  // channel control fields
  parameter int CHNL_CTRL_W   = 4;
  parameter int CTRL_TX_SWAP  = 0;
  parameter int CTRL_RX_SWAP  = 1;
  parameter int CTRL_TX_LPBK  = 2;
  parameter int CTRL_RX_LPBK  = 3;

  // link status enable bits above the state field
  parameter int STAT_TX_XFER = 4;
  parameter int STAT_RX_XFER = 5;

endpackage

// File: source/aib_clk_rst.sv
// ============================================================
// aib clock and reset
// combines the adapter resets, syncs the release into
// fs_fwd_clk and forms the divide-by-two forwarded clock
// ============================================================
`timescale 1ns/1ns

module aib_clk_rst
(
  input  logic fs_fwd_clk,
  input  logic i_ns_adapter_rstn,
  input  logic i_adapter_rstni,
  output logic adpt_rstn_sync_fsfwdclk,
  output logic o_fs_fwd_div2_clk
);

  logic adpt_rstn;
  logic rstn_meta;

  assign adpt_rstn = i_ns_adapter_rstn & i_adapter_rstni;   // either side holds reset

  // two-flop release with asynchronous assert
  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn)
  begin
    if (!adpt_rstn)
    begin
      rstn_meta               <= 1'b0;
      adpt_rstn_sync_fsfwdclk <= 1'b0;
    end
    else
    begin
      rstn_meta               <= 1'b1;
      adpt_rstn_sync_fsfwdclk <= rstn_meta;
    end
  end

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
      o_fs_fwd_div2_clk <= 1'b0;
    else
      o_fs_fwd_div2_clk <= ~o_fs_fwd_div2_clk;   // toggle every edge
  end

endmodule

// File: datapath/aib_tx_chnl.sv
// ============================================================
// aib transmit channel
// register path from mac to io buffer with half swap and
// adapter loopback of the rx register data
// ============================================================
`timescale 1ns/1ns

module aib_tx_chnl
#(
  parameter int DATA_W = 40
)
(
  input  logic                     fs_fwd_clk,
  input  logic                     adpt_rstn_sync_fsfwdclk,
  input  logic [DATA_W-1:0]        i_data_in,        // from mac
  input  logic [DATA_W-1:0]        i_rx_lpbk_data,   // rx register data
  input  logic                     i_swap_en,
  input  aib_link_pkg::lpbk_mode_e i_lpbk_mode,
  output logic [DATA_W-1:0]        o_dout            // to io buffer
);

  localparam int HALF_W = DATA_W / 2;

  logic [DATA_W-1:0] tx_src;
  logic [DATA_W-1:0] tx_word;

  // source select
  always_comb
  begin
    case (i_lpbk_mode)
      aib_link_pkg::LPBK_RX:  tx_src = i_rx_lpbk_data;
      default:                tx_src = i_data_in;
    endcase
  end

  assign tx_word = i_swap_en ? {tx_src[HALF_W-1:0], tx_src[DATA_W-1:HALF_W]} : tx_src;

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
      o_dout <= '0;
    else
      o_dout <= tx_word;
  end

  // ============================================================
  // checks
  // ============================================================

  // swap splits the word in two equal halves
  a_even_width: assert property (
    @(posedge fs_fwd_clk) disable iff (!adpt_rstn_sync_fsfwdclk)
    (DATA_W % 2) == 0
  );

endmodule

// File: datapath/aib_rx_chnl.sv
// ============================================================
// aib receive channel
// register path from io buffer to mac with half swap and
// receive loopback of the tx output
// ============================================================
`timescale 1ns/1ns

module aib_rx_chnl
#(
  parameter int DATA_W = 40
)
(
  input  logic              fs_fwd_clk,
  input  logic              adpt_rstn_sync_fsfwdclk,
  input  logic [DATA_W-1:0] i_din,            // from io buffer
  input  logic [DATA_W-1:0] i_tx_lpbk_data,   // tx output word
  input  logic              i_swap_en,
  input  logic              i_lpbk_en,
  output logic [DATA_W-1:0] o_data_out        // to mac
);

  localparam int HALF_W = DATA_W / 2;

  logic [DATA_W-1:0] rx_src;
  logic [DATA_W-1:0] rx_word;

  assign rx_src = i_lpbk_en ? i_tx_lpbk_data : i_din;

  // upper and lower halves exchanged when enabled
  always_comb
  begin
    if (i_swap_en)
      rx_word = {rx_src[HALF_W-1:0], rx_src[DATA_W-1:HALF_W]};
    else
      rx_word = rx_src;
  end

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
      o_data_out <= '0;
    else
      o_data_out <= rx_word;   // feeds the tx loopback too
  end

endmodule

// File: link/aib_link_sm.sv
// ============================================================
// aib link state machine
// master-mode bring-up: osc transfer, tx dcc calibration,
// rx dll lock, then transfer enable
// ============================================================
`timescale 1ns/1ns

module aib_link_sm
(
  input  logic                      fs_fwd_clk,
  input  logic                      adpt_rstn_sync_fsfwdclk,
  input  logic                      i_conf_done,
  input  logic                      i_tx_dcc_cal_done,
  input  logic                      i_rx_dll_lock,
  output aib_link_pkg::link_state_e o_link_state,
  output logic                      o_osc_transfer_en,
  output logic                      o_tx_dcc_cal_req,
  output logic                      o_rx_dll_lock_req,
  output logic                      o_tx_transfer_en,
  output logic                      o_rx_transfer_en
);

  aib_link_pkg::link_state_e state;
  aib_link_pkg::link_state_e state_nxt;

  // ============================================================
  // next state
  // ============================================================
  always_comb
  begin
    state_nxt = state;
    if (!i_conf_done)
      state_nxt = aib_link_pkg::LINK_RESET;   // restart on lost config
    else
    begin
      case (state)
        aib_link_pkg::LINK_RESET:   state_nxt = aib_link_pkg::LINK_OSC_EN;
        aib_link_pkg::LINK_OSC_EN:  state_nxt = aib_link_pkg::LINK_TX_CAL;
        aib_link_pkg::LINK_TX_CAL:
        begin
          if (i_tx_dcc_cal_done)
            state_nxt = aib_link_pkg::LINK_RX_LOCK;
        end
        aib_link_pkg::LINK_RX_LOCK:
        begin
          if (i_rx_dll_lock)
            state_nxt = aib_link_pkg::LINK_ACTIVE;
        end
        aib_link_pkg::LINK_ACTIVE:  state_nxt = aib_link_pkg::LINK_ACTIVE;
        default:                    state_nxt = aib_link_pkg::LINK_RESET;
      endcase
    end
  end

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
      state <= aib_link_pkg::LINK_RESET;
    else
      state <= state_nxt;
  end

  // ============================================================
  // outputs decoded from state
  // ============================================================
  assign o_link_state      = state;
  assign o_osc_transfer_en = (state != aib_link_pkg::LINK_RESET);
  assign o_tx_dcc_cal_req  = (state == aib_link_pkg::LINK_TX_CAL);
  assign o_rx_dll_lock_req = (state == aib_link_pkg::LINK_RX_LOCK);
  assign o_tx_transfer_en  = (state == aib_link_pkg::LINK_RX_LOCK) ||
                             (state == aib_link_pkg::LINK_ACTIVE);
  assign o_rx_transfer_en  = (state == aib_link_pkg::LINK_ACTIVE);

  // rx side only opens after tx has been running
  a_rx_after_tx: assert property (
    @(posedge fs_fwd_clk) disable iff (!adpt_rstn_sync_fsfwdclk)
    $rose(o_rx_transfer_en) |-> $past(o_tx_transfer_en) && o_tx_transfer_en
  );

endmodule

// File: config/aib_cfg_regs.sv
// ============================================================
// aib config registers
// channel controls, user word and live link status on a
// read/write strobe bus
// ============================================================
`timescale 1ns/1ns

module aib_cfg_regs
(
  input  logic                                 fs_fwd_clk,
  input  logic                                 adpt_rstn_sync_fsfwdclk,
  input  logic [aib_cfg_pkg::CFG_ADDR_W-1:0]   i_cfg_addr,
  input  logic [aib_cfg_pkg::CFG_DATA_W-1:0]   i_cfg_wdata,
  input  logic                                 i_cfg_write,
  input  logic                                 i_cfg_read,
  input  aib_link_pkg::link_state_e            i_link_state,
  input  logic                                 i_tx_transfer_en,
  input  logic                                 i_rx_transfer_en,
  output logic [aib_cfg_pkg::CFG_DATA_W-1:0]   o_cfg_rdata,
  output logic                                 o_cfg_rdatavld,
  output logic [aib_cfg_pkg::CFG_DATA_W-1:0]   o_user_ctrl,
  output logic                                 o_tx_swap_en,
  output logic                                 o_rx_swap_en,
  output aib_link_pkg::lpbk_mode_e             o_tx_lpbk_mode,
  output logic                                 o_rx_lpbk_en
);

  logic [aib_cfg_pkg::CHNL_CTRL_W-1:0] chnl_ctrl;
  logic [aib_cfg_pkg::CFG_DATA_W-1:0]  link_status;
  logic [aib_cfg_pkg::CFG_DATA_W-1:0]  rd_mux;

  // ============================================================
  // write decode
  // ============================================================
  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      chnl_ctrl   <= '0;
      o_user_ctrl <= '0;
    end
    else if (i_cfg_write)
    begin
      case (i_cfg_addr)
        aib_cfg_pkg::CFG_CHNL_CTRL: chnl_ctrl   <= i_cfg_wdata[aib_cfg_pkg::CHNL_CTRL_W-1:0];
        aib_cfg_pkg::CFG_USER_CTRL: o_user_ctrl <= i_cfg_wdata;
        default:                    ;   // status and holes ignore writes
      endcase
    end
  end

  always_comb
  begin
    link_status = '0;
    link_status[aib_link_pkg::LINK_STATE_W-1:0] = i_link_state;
    link_status[aib_cfg_pkg::STAT_TX_XFER]       = i_tx_transfer_en;
    link_status[aib_cfg_pkg::STAT_RX_XFER]       = i_rx_transfer_en;
  end

  // ============================================================
  // one-cycle read path
  // ============================================================
  always_comb
  begin
    case (i_cfg_addr)
      aib_cfg_pkg::CFG_CHNL_CTRL:
        rd_mux = {{(aib_cfg_pkg::CFG_DATA_W-aib_cfg_pkg::CHNL_CTRL_W){1'b0}}, chnl_ctrl};
      aib_cfg_pkg::CFG_USER_CTRL:   rd_mux = o_user_ctrl;
      aib_cfg_pkg::CFG_LINK_STATUS: rd_mux = link_status;
      default:                      rd_mux = '0;
    endcase
  end

  always_ff @(posedge fs_fwd_clk or negedge adpt_rstn_sync_fsfwdclk)
  begin
    if (!adpt_rstn_sync_fsfwdclk)
    begin
      o_cfg_rdata    <= '0;
      o_cfg_rdatavld <= 1'b0;
    end
    else
    begin
      o_cfg_rdatavld <= i_cfg_read;
      if (i_cfg_read)
        o_cfg_rdata <= rd_mux;
    end
  end

  assign o_tx_swap_en   = chnl_ctrl[aib_cfg_pkg::CTRL_TX_SWAP];
  assign o_rx_swap_en   = chnl_ctrl[aib_cfg_pkg::CTRL_RX_SWAP];
  assign o_tx_lpbk_mode = aib_link_pkg::lpbk_mode_e'(chnl_ctrl[aib_cfg_pkg::CTRL_TX_LPBK]);
  assign o_rx_lpbk_en   = chnl_ctrl[aib_cfg_pkg::CTRL_RX_LPBK];

  // single bus master never overlaps strobes
  a_no_rd_wr: assert property (
    @(posedge fs_fwd_clk) disable iff (!adpt_rstn_sync_fsfwdclk)
    !(i_cfg_read && i_cfg_write)
  );

endmodule

// File: source/aib_adapt_top.sv
// ============================================================
// aib adapter top
// single-channel master adapter on fs_fwd_clk: reset, data
// paths, config registers and link bring-up
// ============================================================
`timescale 1ns/1ns

module aib_adapt_top
#(
  parameter int DATA_W = aib_link_pkg::DATA_W
)
(
  input  logic                               fs_fwd_clk,
  input  logic                               i_ns_adapter_rstn,
  input  logic                               i_adapter_rstni,
  input  logic [DATA_W-1:0]                  i_data_in,      // from mac
  input  logic [DATA_W-1:0]                  i_din,          // from io buffer
  input  logic [aib_cfg_pkg::CFG_ADDR_W-1:0] i_cfg_addr,
  input  logic [aib_cfg_pkg::CFG_DATA_W-1:0] i_cfg_wdata,
  input  logic                               i_cfg_write,
  input  logic                               i_cfg_read,
  input  logic                               i_conf_done,
  input  logic                               i_tx_dcc_cal_done,
  input  logic                               i_rx_dll_lock,
  output logic [DATA_W-1:0]                  o_dout,         // to io buffer
  output logic [DATA_W-1:0]                  o_data_out,     // to mac
  output logic                               o_fs_fwd_div2_clk,
  output logic [aib_cfg_pkg::CFG_DATA_W-1:0] o_cfg_rdata,
  output logic                               o_cfg_rdatavld,
  output logic [aib_cfg_pkg::CFG_DATA_W-1:0] o_user_ctrl,
  output logic                               o_osc_transfer_en,
  output logic                               o_tx_dcc_cal_req,
  output logic                               o_rx_dll_lock_req,
  output logic                               o_tx_transfer_en,
  output logic                               o_rx_transfer_en
);

  logic                      adpt_rstn_sync_fsfwdclk;
  logic                      tx_swap_en;
  logic                      rx_swap_en;
  aib_link_pkg::lpbk_mode_e  tx_lpbk_mode;
  logic                      rx_lpbk_en;
  aib_link_pkg::link_state_e link_state;

  aib_clk_rst u_clk_rst
  (
    .fs_fwd_clk              (fs_fwd_clk),
    .i_ns_adapter_rstn       (i_ns_adapter_rstn),
    .i_adapter_rstni         (i_adapter_rstni),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .o_fs_fwd_div2_clk       (o_fs_fwd_div2_clk)
  );

  aib_tx_chnl #(.DATA_W(DATA_W)) u_tx_chnl
  (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_data_in               (i_data_in),
    .i_rx_lpbk_data          (o_data_out),   // adapter loopback
    .i_swap_en               (tx_swap_en),
    .i_lpbk_mode             (tx_lpbk_mode),
    .o_dout                  (o_dout)
  );

  aib_rx_chnl #(.DATA_W(DATA_W)) u_rx_chnl
  (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_din                   (i_din),
    .i_tx_lpbk_data          (o_dout),       // receive loopback
    .i_swap_en               (rx_swap_en),
    .i_lpbk_en               (rx_lpbk_en),
    .o_data_out              (o_data_out)
  );

  aib_link_sm u_link_sm
  (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_conf_done             (i_conf_done),
    .i_tx_dcc_cal_done       (i_tx_dcc_cal_done),
    .i_rx_dll_lock           (i_rx_dll_lock),
    .o_link_state            (link_state),
    .o_osc_transfer_en       (o_osc_transfer_en),
    .o_tx_dcc_cal_req        (o_tx_dcc_cal_req),
    .o_rx_dll_lock_req       (o_rx_dll_lock_req),
    .o_tx_transfer_en        (o_tx_transfer_en),
    .o_rx_transfer_en        (o_rx_transfer_en)
  );

  aib_cfg_regs u_cfg_regs
  (
    .fs_fwd_clk              (fs_fwd_clk),
    .adpt_rstn_sync_fsfwdclk (adpt_rstn_sync_fsfwdclk),
    .i_cfg_addr              (i_cfg_addr),
    .i_cfg_wdata             (i_cfg_wdata),
    .i_cfg_write             (i_cfg_write),
    .i_cfg_read              (i_cfg_read),
    .i_link_state            (link_state),
    .i_tx_transfer_en        (o_tx_transfer_en),
    .i_rx_transfer_en        (o_rx_transfer_en),
    .o_cfg_rdata             (o_cfg_rdata),
    .o_cfg_rdatavld          (o_cfg_rdatavld),
    .o_user_ctrl             (o_user_ctrl),
    .o_tx_swap_en            (tx_swap_en),
    .o_rx_swap_en            (rx_swap_en),
    .o_tx_lpbk_mode          (tx_lpbk_mode),
    .o_rx_lpbk_en            (rx_lpbk_en)
  );

endmodule

// File: bench/aib_adapt_tests.svh
// ============================================================
// aib adapter directed tests
// reset state, register access, data paths, loopbacks and
// link bring-up
// ============================================================
`ifndef AIB_ADAPT_TESTS_SVH
`define AIB_ADAPT_TESTS_SVH

task automatic cfg_write(input logic [16:0] addr, input logic [31:0] data);
  i_cfg_addr  = addr;
  i_cfg_wdata = data;
  i_cfg_write = 1'b1;
  step_cycle();
  i_cfg_write = 1'b0;
endtask

// valid must show up in the one cycle after the strobe only
task automatic cfg_read(input logic [16:0] addr, output logic [31:0] data);
  if (o_cfg_rdatavld !== 1'b0)
    report_mismatch("o_cfg_rdatavld", 64'(o_cfg_rdatavld), 64'd0);
  i_cfg_addr = addr;
  i_cfg_read = 1'b1;
  step_cycle();
  i_cfg_read = 1'b0;
  if (o_cfg_rdatavld !== 1'b1)
    report_mismatch("o_cfg_rdatavld", 64'(o_cfg_rdatavld), 64'd1);
  data = o_cfg_rdata;
  step_cycle();
  if (o_cfg_rdatavld !== 1'b0)
    report_mismatch("o_cfg_rdatavld", 64'(o_cfg_rdatavld), 64'd0);
endtask

task automatic reset_state_check();
  integer n;
  logic   prev;
  if ({o_osc_transfer_en, o_tx_dcc_cal_req, o_rx_dll_lock_req} !== 3'b000)
    report_mismatch("osc_en/cal_req/lock_req", 64'({o_osc_transfer_en,
                    o_tx_dcc_cal_req, o_rx_dll_lock_req}), 64'd0);
  if ({o_tx_transfer_en, o_rx_transfer_en} !== 2'b00)
    report_mismatch("tx/rx_transfer_en", 64'({o_tx_transfer_en, o_rx_transfer_en}), 64'd0);
  if (o_cfg_rdatavld !== 1'b0)
    report_mismatch("o_cfg_rdatavld", 64'(o_cfg_rdatavld), 64'd0);
  if (o_fs_fwd_div2_clk !== 1'b0)
    report_mismatch("o_fs_fwd_div2_clk", 64'(o_fs_fwd_div2_clk), 64'd0);
  if (o_dout !== '0 || o_data_out !== '0)
    report_mismatch("o_dout|o_data_out", 64'(o_dout | o_data_out), 64'd0);
  n = 0;
  while (o_fs_fwd_div2_clk !== 1'b1 && n < WAIT_LIMIT)
  begin
    step_cycle();
    n++;
  end
  if (o_fs_fwd_div2_clk !== 1'b1)
    report_timeout("divided clock never started after reset release");
  else
  begin
    prev = o_fs_fwd_div2_clk;
    repeat (4)
    begin
      step_cycle();
      if (o_fs_fwd_div2_clk !== ~prev)
        report_mismatch("o_fs_fwd_div2_clk", 64'(o_fs_fwd_div2_clk), 64'(!prev));
      prev = o_fs_fwd_div2_clk;
    end
  end
endtask

task automatic register_access();
  logic [31:0] rd;
  logic [31:0] user_word;
  user_word = $random(seed);
  cfg_write(aib_cfg_pkg::CFG_USER_CTRL, user_word);
  cfg_write(aib_cfg_pkg::CFG_CHNL_CTRL, 32'ha5a5_a5aa);   // only bits 3:0 stick
  cfg_write(17'h1_0040, 32'hffff_ffff);                   // unmapped hole
  if (o_user_ctrl !== user_word)
    report_mismatch("o_user_ctrl", 64'(o_user_ctrl), 64'(user_word));
  cfg_read(aib_cfg_pkg::CFG_USER_CTRL, rd);
  if (rd !== user_word)
    report_mismatch("o_cfg_rdata", 64'(rd), 64'(user_word));
  cfg_read(aib_cfg_pkg::CFG_CHNL_CTRL, rd);
  if (rd !== 32'h0000_000a)
    report_mismatch("o_cfg_rdata", 64'(rd), 64'h0000_000a);
  cfg_read(17'h1_0040, rd);
  if (rd !== 32'h0)
    report_mismatch("o_cfg_rdata", 64'(rd), 64'd0);
  cfg_write(aib_cfg_pkg::CFG_CHNL_CTRL, 32'h0);
endtask

task automatic straight_paths();
  logic [DATA_W-1:0] mac_word;
  logic [DATA_W-1:0] io_word;
  logic [DATA_W-1:0] exp_tx;
  logic [DATA_W-1:0] exp_rx;
  integer            pass;
  integer            i;
  for (pass = 0; pass < 2; pass++)
  begin
    cfg_write(aib_cfg_pkg::CFG_CHNL_CTRL, (pass == 1) ? 32'h3 : 32'h0);   // both swaps
    for (i = 0; i < 8; i++)
    begin
      mac_word  = rand_word();
      io_word   = rand_word();
      i_data_in = mac_word;
      i_din     = io_word;
      exp_tx    = (pass == 1) ? halves_swapped(mac_word) : mac_word;
      exp_rx    = (pass == 1) ? halves_swapped(io_word) : io_word;
      step_cycle();
      if (o_dout !== exp_tx)
        report_mismatch("o_dout", 64'(o_dout), 64'(exp_tx));
      if (o_data_out !== exp_rx)
        report_mismatch("o_data_out", 64'(o_data_out), 64'(exp_rx));
    end
  end
  cfg_write(aib_cfg_pkg::CFG_CHNL_CTRL, 32'h0);
endtask

task automatic loopback_paths();
  logic [DATA_W-1:0] w;
  integer            i;
  cfg_write(aib_cfg_pkg::CFG_CHNL_CTRL, 32'h8);   // rx loopback
  for (i = 0; i < 6; i++)
  begin
    w         = rand_word();
    i_data_in = w;
    i_din     = rand_word();   // must be ignored
    step_cycle();
    i_data_in = rand_word();
    step_cycle();
    if (o_data_out !== w)
      report_mismatch("o_data_out", 64'(o_data_out), 64'(w));
  end
  cfg_write(aib_cfg_pkg::CFG_CHNL_CTRL, 32'h4);   // tx adapter loopback
  for (i = 0; i < 6; i++)
  begin
    w         = rand_word();
    i_din     = w;
    i_data_in = rand_word();
    step_cycle();
    i_din = rand_word();
    step_cycle();
    if (o_dout !== w)
      report_mismatch("o_dout", 64'(o_dout), 64'(w));
  end
  cfg_write(aib_cfg_pkg::CFG_CHNL_CTRL, 32'h0);
endtask

task automatic link_bringup();
  integer      n;
  logic [31:0] rd;
  i_conf_done = 1'b1;
  n = 0;
  while (o_tx_dcc_cal_req !== 1'b1 && n < WAIT_LIMIT)
  begin
    step_cycle();
    n++;
  end
  if (o_tx_dcc_cal_req !== 1'b1)
    report_timeout("no tx dcc calibration request");
  if (o_osc_transfer_en !== 1'b1)
    report_mismatch("o_osc_transfer_en", 64'(o_osc_transfer_en), 64'd1);
  i_tx_dcc_cal_done = 1'b1;
  n = 0;
  while (o_rx_dll_lock_req !== 1'b1 && n < WAIT_LIMIT)
  begin
    step_cycle();
    n++;
  end
  if (o_rx_dll_lock_req !== 1'b1)
    report_timeout("no rx dll lock request");
  if (o_tx_transfer_en !== 1'b1)
    report_mismatch("o_tx_transfer_en", 64'(o_tx_transfer_en), 64'd1);
  i_rx_dll_lock = 1'b1;
  n = 0;
  while ((o_tx_transfer_en !== 1'b1 || o_rx_transfer_en !== 1'b1) && n < WAIT_LIMIT)
  begin
    step_cycle();
    n++;
  end
  if (o_tx_transfer_en !== 1'b1 || o_rx_transfer_en !== 1'b1)
    report_timeout("transfer enables never both came up");
  cfg_read(aib_cfg_pkg::CFG_LINK_STATUS, rd);
  if (rd !== {26'd0, 1'b1, 1'b1, 1'b0, 3'd4})   // rx_en, tx_en, state active
    report_mismatch("o_cfg_rdata", 64'(rd), 64'({26'd0, 1'b1, 1'b1, 1'b0, 3'd4}));
  i_conf_done       = 1'b0;
  i_tx_dcc_cal_done = 1'b0;
  i_rx_dll_lock     = 1'b0;
  step_cycle();
  if ({o_tx_transfer_en, o_rx_transfer_en} !== 2'b00)
    report_mismatch("tx/rx_transfer_en", 64'({o_tx_transfer_en, o_rx_transfer_en}), 64'd0);
  cfg_read(aib_cfg_pkg::CFG_LINK_STATUS, rd);
  if (rd !== 32'h0)
    report_mismatch("o_cfg_rdata", 64'(rd), 64'd0);
endtask

`endif

// File: bench/tb_aib_adapt.sv
// ============================================================
// aib adapter testbench
// clock, reset, DUT and error counters around the directed
// tests of the single-channel adapter
// ============================================================
`timescale 1ns/1ns

module tb_aib_adapt;

  localparam int DATA_W     = 40;
  localparam int HALF_W     = DATA_W / 2;
  localparam int WAIT_LIMIT = 50;   // cycles per wait loop

  logic              fs_fwd_clk;
  logic              i_ns_adapter_rstn;
  logic              i_adapter_rstni;
  logic [DATA_W-1:0] i_data_in;
  logic [DATA_W-1:0] i_din;
  logic [16:0]       i_cfg_addr;
  logic [31:0]       i_cfg_wdata;
  logic              i_cfg_write;
  logic              i_cfg_read;
  logic              i_conf_done;
  logic              i_tx_dcc_cal_done;
  logic              i_rx_dll_lock;
  logic [DATA_W-1:0] o_dout;
  logic [DATA_W-1:0] o_data_out;
  logic              o_fs_fwd_div2_clk;
  logic [31:0]       o_cfg_rdata;
  logic              o_cfg_rdatavld;
  logic [31:0]       o_user_ctrl;
  logic              o_osc_transfer_en;
  logic              o_tx_dcc_cal_req;
  logic              o_rx_dll_lock_req;
  logic              o_tx_transfer_en;
  logic              o_rx_transfer_en;

  integer seed;
  integer err_count;
  integer timeout_count;

  aib_adapt_top #(.DATA_W(DATA_W)) u_dut
  (
    .fs_fwd_clk        (fs_fwd_clk),
    .i_ns_adapter_rstn (i_ns_adapter_rstn),
    .i_adapter_rstni   (i_adapter_rstni),
    .i_data_in         (i_data_in),
    .i_din             (i_din),
    .i_cfg_addr        (i_cfg_addr),
    .i_cfg_wdata       (i_cfg_wdata),
    .i_cfg_write       (i_cfg_write),
    .i_cfg_read        (i_cfg_read),
    .i_conf_done       (i_conf_done),
    .i_tx_dcc_cal_done (i_tx_dcc_cal_done),
    .i_rx_dll_lock     (i_rx_dll_lock),
    .o_dout            (o_dout),
    .o_data_out        (o_data_out),
    .o_fs_fwd_div2_clk (o_fs_fwd_div2_clk),
    .o_cfg_rdata       (o_cfg_rdata),
    .o_cfg_rdatavld    (o_cfg_rdatavld),
    .o_user_ctrl       (o_user_ctrl),
    .o_osc_transfer_en (o_osc_transfer_en),
    .o_tx_dcc_cal_req  (o_tx_dcc_cal_req),
    .o_rx_dll_lock_req (o_rx_dll_lock_req),
    .o_tx_transfer_en  (o_tx_transfer_en),
    .o_rx_transfer_en  (o_rx_transfer_en)
  );

  initial
  begin
    fs_fwd_clk = 1'b0;
    forever #5 fs_fwd_clk = ~fs_fwd_clk;   // 10 ns period
  end

  // ============================================================
  // helpers
  // ============================================================

  // one rising edge plus 1 ns to drive and sample
  task automatic step_cycle();
    @(posedge fs_fwd_clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    err_count++;
    $display("ERR %s got 0x%0h exp 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("timeout at %0t: %s", $time, what);
  endtask

  // rotate by half a word
  function automatic logic [DATA_W-1:0] halves_swapped(input logic [DATA_W-1:0] w);
    halves_swapped = (w << HALF_W) | (w >> HALF_W);
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    logic [63:0] raw;
    raw = {$random(seed), $random(seed)};
    rand_word = raw[DATA_W-1:0];
  endfunction

  `include "aib_adapt_tests.svh"

  // ============================================================
  // main sequence
  // ============================================================
  initial
  begin
    seed              = 32'h8227935d;
    err_count         = 0;
    timeout_count     = 0;
    i_ns_adapter_rstn = 1'b0;
    i_adapter_rstni   = 1'b0;
    i_data_in         = '0;
    i_din             = '0;
    i_cfg_addr        = '0;
    i_cfg_wdata       = '0;
    i_cfg_write       = 1'b0;
    i_cfg_read        = 1'b0;
    i_conf_done       = 1'b0;
    i_tx_dcc_cal_done = 1'b0;
    i_rx_dll_lock     = 1'b0;
    repeat (3) step_cycle();
    i_ns_adapter_rstn = 1'b1;
    i_adapter_rstni   = 1'b1;

    reset_state_check();
    register_access();
    straight_paths();
    loopback_paths();
    link_bringup();

    $display("result: %0d value errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: aib_adapt.f
+incdir+bench
common/aib_link_pkg.sv
common/aib_cfg_pkg.sv
source/aib_clk_rst.sv
datapath/aib_tx_chnl.sv
datapath/aib_rx_chnl.sv
link/aib_link_sm.sv
config/aib_cfg_regs.sv
source/aib_adapt_top.sv
bench/tb_aib_adapt.sv

// File: Makefile
# Verilator build and run of the AIB adapter testbench

VERILATOR ?= verilator
TOP       ?= tb_aib_adapt
FLIST     ?= aib_adapt.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST)) bench/aib_adapt_tests.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^TEST PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
